// File: source/apb5_pkg.sv
/*
 * APB5 subsystem shared definitions
 * Bus widths, queue depths, register map and queue payload types
 */
`default_nettype none

package apb5_pkg;

    localparam int ADDR_WIDTH  = 8;
    localparam int DATA_WIDTH  = 32;
    localparam int STRB_WIDTH  = 4;
    localparam int PROT_WIDTH  = 3;
    localparam int AUSER_WIDTH = 4;
    localparam int WUSER_WIDTH = 4;
    localparam int RUSER_WIDTH = 4;
    localparam int BUSER_WIDTH = 4;

    localparam int CMD_DEPTH = 4;
    localparam int RSP_DEPTH = 4;

    // Register map, index is byte address / 4
    localparam int REG_COUNT    = 16;
    localparam int REG_WAIT_CFG = 0;
    localparam int REG_DOORBELL = 1;
    // Writes from here up need PPROT[0]
    localparam int PROT_BASE    = 8;

    typedef struct packed {
        logic                   pwrite;
        logic [ADDR_WIDTH-1:0]  paddr;
        logic [DATA_WIDTH-1:0]  pwdata;
        logic [STRB_WIDTH-1:0]  pstrb;
        logic [PROT_WIDTH-1:0]  pprot;
        logic [AUSER_WIDTH-1:0] pauser;
        logic [WUSER_WIDTH-1:0] pwuser;
    } apb_cmd_t;

    typedef struct packed {
        logic                   pslverr;
        logic                   pwakeup;
        logic [DATA_WIDTH-1:0]  prdata;
        logic [RUSER_WIDTH-1:0] pruser;
        logic [BUSER_WIDTH-1:0] pbuser;
    } apb_rsp_t;

    // One XOR bit per data byte
    function automatic logic [STRB_WIDTH-1:0] byte_parity(input logic [DATA_WIDTH-1:0] data);
        logic [STRB_WIDTH-1:0] par;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            par[i] = ^data[i*8 +: 8];
        end
        return par;
    endfunction

endpackage

`default_nettype wire

// File: source/apb_fifo.sv
/*
 * Synchronous FIFO for any packed payload type
 * Circular buffer with registered not-full ready and occupancy count
 */
`default_nettype none

module apb_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                         pclk,
    input  logic                         rst,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  payload_t                     wr_data,
    output logic                         rd_valid,
    input  logic                         rd_ready,
    output payload_t                     rd_data,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count_next;
    logic                 wr_fire;
    logic                 rd_fire;

    assign wr_fire    = wr_valid && wr_ready;
    assign rd_fire    = rd_valid && rd_ready;
    assign rd_valid   = (count != '0);
    assign rd_data    = mem[rd_ptr];
    assign count_next = count + CNT_W'(wr_fire) - CNT_W'(rd_fire);

    always_ff @(posedge pclk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wr_ready <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count_next;
            // Registered so it already reflects this edge's push and pop
            wr_ready <= (count_next != CNT_W'(DEPTH));
        end
    end

    // Payload storage
    always_ff @(posedge pclk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: source/apb5_master.sv
/*
 * APB5 requester fed by a command queue, answering through a response queue
 * Runs IDLE/SETUP/ACCESS, generates and checks parity, tracks PWAKEUP
 */
`default_nettype none

module apb5_master (
    input  logic                               pclk,
    input  logic                               rst,

    input  logic                               cmd_valid,
    output logic                               cmd_ready,
    input  logic                               cmd_pwrite,
    input  logic [apb5_pkg::ADDR_WIDTH-1:0]    cmd_paddr,
    input  logic [apb5_pkg::DATA_WIDTH-1:0]    cmd_pwdata,
    input  logic [apb5_pkg::STRB_WIDTH-1:0]    cmd_pstrb,
    input  logic [apb5_pkg::PROT_WIDTH-1:0]    cmd_pprot,
    input  logic [apb5_pkg::AUSER_WIDTH-1:0]   cmd_pauser,
    input  logic [apb5_pkg::WUSER_WIDTH-1:0]   cmd_pwuser,

    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output logic [apb5_pkg::DATA_WIDTH-1:0]    rsp_prdata,
    output logic                               rsp_pslverr,
    output logic                               rsp_pwakeup,
    output logic [apb5_pkg::RUSER_WIDTH-1:0]   rsp_pruser,
    output logic [apb5_pkg::BUSER_WIDTH-1:0]   rsp_pbuser,

    output logic                               parity_error_rdata,
    output logic                               parity_error_ctrl,
    output logic                               wakeup_pending,

    output logic                               m_apb_PSEL,
    output logic                               m_apb_PENABLE,
    output logic [apb5_pkg::ADDR_WIDTH-1:0]    m_apb_PADDR,
    output logic                               m_apb_PWRITE,
    output logic [apb5_pkg::DATA_WIDTH-1:0]    m_apb_PWDATA,
    output logic [apb5_pkg::STRB_WIDTH-1:0]    m_apb_PSTRB,
    output logic [apb5_pkg::PROT_WIDTH-1:0]    m_apb_PPROT,
    output logic [apb5_pkg::AUSER_WIDTH-1:0]   m_apb_PAUSER,
    output logic [apb5_pkg::WUSER_WIDTH-1:0]   m_apb_PWUSER,
    output logic [apb5_pkg::STRB_WIDTH-1:0]    m_apb_PWDATAPARITY,
    output logic                               m_apb_PADDRPARITY,
    output logic                               m_apb_PCTRLPARITY,
    input  logic [apb5_pkg::DATA_WIDTH-1:0]    m_apb_PRDATA,
    input  logic                               m_apb_PREADY,
    input  logic                               m_apb_PSLVERR,
    input  logic [apb5_pkg::RUSER_WIDTH-1:0]   m_apb_PRUSER,
    input  logic [apb5_pkg::BUSER_WIDTH-1:0]   m_apb_PBUSER,
    input  logic                               m_apb_PWAKEUP,
    input  logic [apb5_pkg::STRB_WIDTH-1:0]    m_apb_PRDATAPARITY,
    input  logic                               m_apb_PREADYPARITY,
    input  logic                               m_apb_PSLVERRPARITY
);

    import apb5_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } state_t;

    state_t                           state;
    state_t                           state_next;
    apb_cmd_t                         cmd_in;
    apb_cmd_t                         cmd_head;
    apb_rsp_t                         rsp_in;
    apb_rsp_t                         rsp_out;
    logic                             cmd_head_valid;
    logic [$clog2(CMD_DEPTH+1)-1:0]   cmd_count;
    logic [$clog2(RSP_DEPTH+1)-1:0]   rsp_count;
    logic                             rsp_room;
    logic                             complete;

    assign cmd_in = '{pwrite: cmd_pwrite, paddr: cmd_paddr, pwdata: cmd_pwdata,
                      pstrb: cmd_pstrb, pprot: cmd_pprot, pauser: cmd_pauser,
                      pwuser: cmd_pwuser};

    apb_fifo #(.payload_t(apb_cmd_t), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
        .pclk     (pclk),
        .rst      (rst),
        .wr_valid (cmd_valid),
        .wr_ready (cmd_ready),
        .wr_data  (cmd_in),
        .rd_valid (cmd_head_valid),
        .rd_ready (complete),
        .rd_data  (cmd_head),
        .count    (cmd_count)
    );

    // Completion always has a slot, room was checked when the transfer started
    assign rsp_in = '{pslverr: m_apb_PSLVERR, pwakeup: m_apb_PWAKEUP, prdata: m_apb_PRDATA,
                      pruser: m_apb_PRUSER, pbuser: m_apb_PBUSER};

    apb_fifo #(.payload_t(apb_rsp_t), .DEPTH(RSP_DEPTH)) u_rsp_fifo (
        .pclk     (pclk),
        .rst      (rst),
        .wr_valid (complete),
        .wr_ready (rsp_room),
        .wr_data  (rsp_in),
        .rd_valid (rsp_valid),
        .rd_ready (rsp_ready),
        .rd_data  (rsp_out),
        .count    (rsp_count)
    );

    assign rsp_pslverr = rsp_out.pslverr;
    assign rsp_pwakeup = rsp_out.pwakeup;
    assign rsp_prdata  = rsp_out.prdata;
    assign rsp_pruser  = rsp_out.pruser;
    assign rsp_pbuser  = rsp_out.pbuser;

    // Request fields come straight off the queue head, stable until the pop
    assign m_apb_PSEL    = (state != IDLE);
    assign m_apb_PENABLE = (state == ACCESS);
    assign m_apb_PADDR   = cmd_head.paddr;
    assign m_apb_PWRITE  = cmd_head.pwrite;
    assign m_apb_PWDATA  = cmd_head.pwdata;
    assign m_apb_PSTRB   = cmd_head.pstrb;
    assign m_apb_PPROT   = cmd_head.pprot;
    assign m_apb_PAUSER  = cmd_head.pauser;
    assign m_apb_PWUSER  = cmd_head.pwuser;

    assign m_apb_PWDATAPARITY = byte_parity(cmd_head.pwdata);
    assign m_apb_PADDRPARITY  = ^cmd_head.paddr;
    assign m_apb_PCTRLPARITY  = ^{cmd_head.pwrite, cmd_head.pstrb, cmd_head.pprot};

    assign complete = (state == ACCESS) && m_apb_PREADY;

    // Response side parity, only meaningful on the completing cycle
    assign parity_error_rdata = complete &&
                                (byte_parity(m_apb_PRDATA) != m_apb_PRDATAPARITY);
    assign parity_error_ctrl  = complete && ((m_apb_PREADY != m_apb_PREADYPARITY) ||
                                             (m_apb_PSLVERR != m_apb_PSLVERRPARITY));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cmd_head_valid && rsp_room) begin
                    state_next = SETUP;
                end
            end
            SETUP: state_next = ACCESS;
            ACCESS: begin
                if (m_apb_PREADY) begin
                    // Back to back needs a second command and a second free slot
                    if (cmd_count > 1 && rsp_count < RSP_DEPTH - 1) begin
                        state_next = SETUP;
                    end else begin
                        state_next = IDLE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            state          <= IDLE;
            wakeup_pending <= 1'b0;
        end else begin
            state <= state_next;
            if (m_apb_PWAKEUP) begin
                wakeup_pending <= 1'b1;
            end else if (state_next == SETUP) begin
                wakeup_pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/apb5_reg_slave.sv
/*
 * APB5 completer with a 16 x 32 register bank
 * Programmable wait states, protection and range errors, doorbell wakeup
 */
`default_nettype none

module apb5_reg_slave (
    input  logic                               pclk,
    input  logic                               rst,

    input  logic                               s_apb_PSEL,
    input  logic                               s_apb_PENABLE,
    input  logic [apb5_pkg::ADDR_WIDTH-1:0]    s_apb_PADDR,
    input  logic                               s_apb_PWRITE,
    input  logic [apb5_pkg::DATA_WIDTH-1:0]    s_apb_PWDATA,
    input  logic [apb5_pkg::STRB_WIDTH-1:0]    s_apb_PSTRB,
    input  logic [apb5_pkg::PROT_WIDTH-1:0]    s_apb_PPROT,
    input  logic [apb5_pkg::AUSER_WIDTH-1:0]   s_apb_PAUSER,
    input  logic [apb5_pkg::WUSER_WIDTH-1:0]   s_apb_PWUSER,
    input  logic [apb5_pkg::STRB_WIDTH-1:0]    s_apb_PWDATAPARITY,
    input  logic                               s_apb_PADDRPARITY,
    input  logic                               s_apb_PCTRLPARITY,
    output logic [apb5_pkg::DATA_WIDTH-1:0]    s_apb_PRDATA,
    output logic                               s_apb_PREADY,
    output logic                               s_apb_PSLVERR,
    output logic [apb5_pkg::RUSER_WIDTH-1:0]   s_apb_PRUSER,
    output logic [apb5_pkg::BUSER_WIDTH-1:0]   s_apb_PBUSER,
    output logic                               s_apb_PWAKEUP,
    output logic [apb5_pkg::STRB_WIDTH-1:0]    s_apb_PRDATAPARITY,
    output logic                               s_apb_PREADYPARITY,
    output logic                               s_apb_PSLVERRPARITY
);

    import apb5_pkg::*;

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [DATA_WIDTH-1:0]    regs      [REG_COUNT];
    logic [RUSER_WIDTH-1:0]   wuser_mem [REG_COUNT];
    logic [BUSER_WIDTH-1:0]   auser_mem [REG_COUNT];
    logic [ADDR_WIDTH-3:0]    word_idx;
    logic [IDX_W-1:0]         reg_idx;
    logic [1:0]               wait_cnt;
    logic                     access;
    logic                     range_err;
    logic                     prot_err;
    logic                     parity_err;
    logic                     err;
    logic                     rd_ok;

    assign word_idx = s_apb_PADDR[ADDR_WIDTH-1:2];
    assign reg_idx  = word_idx[IDX_W-1:0];
    assign access   = s_apb_PSEL && s_apb_PENABLE;

    assign range_err  = (word_idx >= REG_COUNT);
    assign prot_err   = s_apb_PWRITE && (word_idx >= PROT_BASE) && !s_apb_PPROT[0];
    assign parity_err = (byte_parity(s_apb_PWDATA) != s_apb_PWDATAPARITY) ||
                        (^s_apb_PADDR != s_apb_PADDRPARITY) ||
                        (^{s_apb_PWRITE, s_apb_PSTRB, s_apb_PPROT} != s_apb_PCTRLPARITY);
    assign err        = range_err || prot_err || parity_err;

    // Wait count latched in setup, so a new WAIT_CFG applies from the next access
    always_ff @(posedge pclk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (s_apb_PSEL && !s_apb_PENABLE) begin
            wait_cnt <= regs[REG_WAIT_CFG][1:0];
        end else if (access && wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign s_apb_PREADY = access && (wait_cnt == '0);

    always_ff @(posedge pclk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i]      <= '0;
                wuser_mem[i] <= '0;
                auser_mem[i] <= '0;
            end
        end else if (s_apb_PREADY && !err) begin
            if (s_apb_PWRITE) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (s_apb_PSTRB[b]) begin
                        regs[reg_idx][b*8 +: 8] <= s_apb_PWDATA[b*8 +: 8];
                    end
                end
                // Writer attributes, returned on later reads
                wuser_mem[reg_idx] <= s_apb_PWUSER;
                auser_mem[reg_idx] <= s_apb_PAUSER;
            end else if (reg_idx == IDX_W'(REG_DOORBELL)) begin
                // Reading the doorbell acknowledges it
                regs[REG_DOORBELL] <= '0;
            end
        end
    end

    assign rd_ok        = access && !s_apb_PWRITE && !err;
    assign s_apb_PRDATA = rd_ok ? regs[reg_idx] : '0;
    assign s_apb_PRUSER = rd_ok ? wuser_mem[reg_idx] : '0;
    assign s_apb_PBUSER = rd_ok ? auser_mem[reg_idx] : '0;

    assign s_apb_PSLVERR = s_apb_PREADY && err;
    assign s_apb_PWAKEUP = (regs[REG_DOORBELL] != '0);

    assign s_apb_PRDATAPARITY  = byte_parity(s_apb_PRDATA);
    assign s_apb_PREADYPARITY  = s_apb_PREADY;
    assign s_apb_PSLVERRPARITY = s_apb_PSLVERR;

endmodule

`default_nettype wire

// File: source/apb5_subsys_top.sv
/*
 * APB5 subsystem, requester and register completer on one internal bus
 */
`default_nettype none

module apb5_subsys_top (
    input  logic                               pclk,
    input  logic                               rst,

    input  logic                               cmd_valid,
    output logic                               cmd_ready,
    input  logic                               cmd_pwrite,
    input  logic [apb5_pkg::ADDR_WIDTH-1:0]    cmd_paddr,
    input  logic [apb5_pkg::DATA_WIDTH-1:0]    cmd_pwdata,
    input  logic [apb5_pkg::STRB_WIDTH-1:0]    cmd_pstrb,
    input  logic [apb5_pkg::PROT_WIDTH-1:0]    cmd_pprot,
    input  logic [apb5_pkg::AUSER_WIDTH-1:0]   cmd_pauser,
    input  logic [apb5_pkg::WUSER_WIDTH-1:0]   cmd_pwuser,

    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output logic [apb5_pkg::DATA_WIDTH-1:0]    rsp_prdata,
    output logic                               rsp_pslverr,
    output logic                               rsp_pwakeup,
    output logic [apb5_pkg::RUSER_WIDTH-1:0]   rsp_pruser,
    output logic [apb5_pkg::BUSER_WIDTH-1:0]   rsp_pbuser,

    output logic                               parity_error_rdata,
    output logic                               parity_error_ctrl,
    output logic                               wakeup_pending
);

    import apb5_pkg::*;

    // Internal APB5 bus, named after the requester's ports
    logic                     m_apb_PSEL;
    logic                     m_apb_PENABLE;
    logic                     m_apb_PWRITE;
    logic [ADDR_WIDTH-1:0]    m_apb_PADDR;
    logic [DATA_WIDTH-1:0]    m_apb_PWDATA;
    logic [STRB_WIDTH-1:0]    m_apb_PSTRB;
    logic [PROT_WIDTH-1:0]    m_apb_PPROT;
    logic [AUSER_WIDTH-1:0]   m_apb_PAUSER;
    logic [WUSER_WIDTH-1:0]   m_apb_PWUSER;
    logic [STRB_WIDTH-1:0]    m_apb_PWDATAPARITY;
    logic                     m_apb_PADDRPARITY;
    logic                     m_apb_PCTRLPARITY;
    logic [DATA_WIDTH-1:0]    m_apb_PRDATA;
    logic                     m_apb_PREADY;
    logic                     m_apb_PSLVERR;
    logic [RUSER_WIDTH-1:0]   m_apb_PRUSER;
    logic [BUSER_WIDTH-1:0]   m_apb_PBUSER;
    logic                     m_apb_PWAKEUP;
    logic [STRB_WIDTH-1:0]    m_apb_PRDATAPARITY;
    logic                     m_apb_PREADYPARITY;
    logic                     m_apb_PSLVERRPARITY;

    // Every requester port has a same-named port or net here
    apb5_master u_master (.*);

    apb5_reg_slave u_slave (
        .pclk                (pclk),
        .rst                 (rst),
        .s_apb_PSEL          (m_apb_PSEL),
        .s_apb_PENABLE       (m_apb_PENABLE),
        .s_apb_PADDR         (m_apb_PADDR),
        .s_apb_PWRITE        (m_apb_PWRITE),
        .s_apb_PWDATA        (m_apb_PWDATA),
        .s_apb_PSTRB         (m_apb_PSTRB),
        .s_apb_PPROT         (m_apb_PPROT),
        .s_apb_PAUSER        (m_apb_PAUSER),
        .s_apb_PWUSER        (m_apb_PWUSER),
        .s_apb_PWDATAPARITY  (m_apb_PWDATAPARITY),
        .s_apb_PADDRPARITY   (m_apb_PADDRPARITY),
        .s_apb_PCTRLPARITY   (m_apb_PCTRLPARITY),
        .s_apb_PRDATA        (m_apb_PRDATA),
        .s_apb_PREADY        (m_apb_PREADY),
        .s_apb_PSLVERR       (m_apb_PSLVERR),
        .s_apb_PRUSER        (m_apb_PRUSER),
        .s_apb_PBUSER        (m_apb_PBUSER),
        .s_apb_PWAKEUP       (m_apb_PWAKEUP),
        .s_apb_PRDATAPARITY  (m_apb_PRDATAPARITY),
        .s_apb_PREADYPARITY  (m_apb_PREADYPARITY),
        .s_apb_PSLVERRPARITY (m_apb_PSLVERRPARITY)
    );

endmodule

`default_nettype wire

// File: verif/apb5_subsys_props.sv
/*
 * APB5 bus protocol assertions, bound into the requester
 */
`default_nettype none

module apb5_subsys_props (
    input logic                               pclk,
    input logic                               rst,
    input logic                               m_apb_PSEL,
    input logic                               m_apb_PENABLE,
    input logic [apb5_pkg::ADDR_WIDTH-1:0]    m_apb_PADDR,
    input logic                               m_apb_PWRITE,
    input logic [apb5_pkg::DATA_WIDTH-1:0]    m_apb_PWDATA,
    input logic [apb5_pkg::STRB_WIDTH-1:0]    m_apb_PSTRB,
    input logic [apb5_pkg::PROT_WIDTH-1:0]    m_apb_PPROT,
    input logic [apb5_pkg::AUSER_WIDTH-1:0]   m_apb_PAUSER,
    input logic [apb5_pkg::WUSER_WIDTH-1:0]   m_apb_PWUSER,
    input logic                               m_apb_PREADY,
    input logic                               parity_error_rdata,
    input logic                               parity_error_ctrl
);

    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge pclk) disable iff (rst) m_apb_PENABLE |-> m_apb_PSEL)
        else $error("PENABLE high while PSEL is low");

    // Every access phase follows a setup phase
    assert property (@(posedge pclk) disable iff (rst)
        $rose(m_apb_PENABLE) |-> $past(m_apb_PSEL && !m_apb_PENABLE))
        else $error("PENABLE rose without a setup cycle");

    assert property (@(posedge pclk) disable iff (rst)
        (m_apb_PSEL && !(m_apb_PENABLE && m_apb_PREADY)) |=>
        (m_apb_PSEL && $stable(m_apb_PADDR) && $stable(m_apb_PWRITE) &&
         $stable(m_apb_PWDATA) && $stable(m_apb_PSTRB) && $stable(m_apb_PPROT) &&
         $stable(m_apb_PAUSER) && $stable(m_apb_PWUSER)))
        else $error("Request changed before PREADY");

    assert property (@(posedge pclk) disable iff (rst) !parity_error_rdata && !parity_error_ctrl)
        else $error("Parity error flag raised");

endmodule

bind apb5_master apb5_subsys_props props_i (.*);

`default_nettype wire

// File: verif/apb5_subsys_tb.sv
/*
 * Testbench for the APB5 subsystem
 * Directed and LFSR-driven commands checked against a register model
 */
`default_nettype none

module apb5_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import apb5_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 5;
    localparam int          N_RANDOM     = 200;
    localparam int          N_DIRECTED   = 9;
    localparam int          N_CMDS       = N_RANDOM + N_DIRECTED;
    localparam int          IDX_W        = $clog2(REG_COUNT);
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic                   pclk;
    logic                   rst;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic                   cmd_pwrite;
    logic [ADDR_WIDTH-1:0]  cmd_paddr;
    logic [DATA_WIDTH-1:0]  cmd_pwdata;
    logic [STRB_WIDTH-1:0]  cmd_pstrb;
    logic [PROT_WIDTH-1:0]  cmd_pprot;
    logic [AUSER_WIDTH-1:0] cmd_pauser;
    logic [WUSER_WIDTH-1:0] cmd_pwuser;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic [DATA_WIDTH-1:0]  rsp_prdata;
    logic                   rsp_pslverr;
    logic                   rsp_pwakeup;
    logic [RUSER_WIDTH-1:0] rsp_pruser;
    logic [BUSER_WIDTH-1:0] rsp_pbuser;
    logic                   parity_error_rdata;
    logic                   parity_error_ctrl;
    logic                   wakeup_pending;

    logic [31:0]            lfsr;
    logic [DATA_WIDTH-1:0]  model_regs  [REG_COUNT];
    logic [WUSER_WIDTH-1:0] model_wuser [REG_COUNT];
    logic [AUSER_WIDTH-1:0] model_auser [REG_COUNT];
    apb_rsp_t               exp_q [$];
    int                     cmds_sent;
    int                     rsps_seen;
    int                     errors;

    apb5_subsys_top dut_i (.*);

    initial pclk = 1'b0;
    always #(CLK_PERIOD / 2) pclk = ~pclk;

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] want);
        if (got !== want) begin
            report_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            report_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_user(input string name, input logic [RUSER_WIDTH-1:0] got,
                              input logic [RUSER_WIDTH-1:0] want);
        if (got !== want) begin
            report_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    // Register model, applied in command order
    function automatic apb_rsp_t predict(input apb_cmd_t c);
        apb_rsp_t         rsp;
        logic [IDX_W-1:0] ridx;
        logic             bad;
        rsp  = '0;
        ridx = c.paddr[IDX_W+1:2];
        bad  = (c.paddr[ADDR_WIDTH-1:IDX_W+2] != '0) ||
               (c.pwrite && int'(ridx) >= PROT_BASE && !c.pprot[0]);
        rsp.pslverr = bad;
        // Wakeup reflects the doorbell as it stood before this access
        rsp.pwakeup = (model_regs[REG_DOORBELL] != '0);
        if (!bad && c.pwrite) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (c.pstrb[b]) begin
                    model_regs[ridx][b*8 +: 8] = c.pwdata[b*8 +: 8];
                end
            end
            model_wuser[ridx] = c.pwuser;
            model_auser[ridx] = c.pauser;
        end else if (!bad) begin
            rsp.prdata = model_regs[ridx];
            rsp.pruser = model_wuser[ridx];
            rsp.pbuser = model_auser[ridx];
            if (ridx == IDX_W'(REG_DOORBELL)) begin
                model_regs[REG_DOORBELL] = '0;
            end
        end
        return rsp;
    endfunction

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send_cmd(input apb_cmd_t c);
        logic taken;
        exp_q.push_back(predict(c));
        cmd_valid  = 1'b1;
        cmd_pwrite = c.pwrite;
        cmd_paddr  = c.paddr;
        cmd_pwdata = c.pwdata;
        cmd_pstrb  = c.pstrb;
        cmd_pprot  = c.pprot;
        cmd_pauser = c.pauser;
        cmd_pwuser = c.pwuser;
        do begin
            @(negedge pclk);
            taken = cmd_ready;
            @(posedge pclk);
        end while (!taken);
        #1;
        cmd_valid = 1'b0;
        cmds_sent++;
    endtask

    task automatic random_cmd();
        apb_cmd_t    c;
        logic [31:0] r;
        logic        outside;
        r        = rand_bits(1);
        c.pwrite = r[0];
        // One access in eight lands past the register bank
        r        = rand_bits(3);
        outside  = (r[2:0] == 3'd0);
        r        = rand_bits(6);
        c.paddr  = {1'b0, outside, r[5:0]};
        c.pwdata = rand_bits(DATA_WIDTH);
        r        = rand_bits(STRB_WIDTH);
        c.pstrb  = r[STRB_WIDTH-1:0];
        r        = rand_bits(PROT_WIDTH);
        c.pprot  = r[PROT_WIDTH-1:0];
        r        = rand_bits(AUSER_WIDTH);
        c.pauser = r[AUSER_WIDTH-1:0];
        r        = rand_bits(WUSER_WIDTH);
        c.pwuser = r[WUSER_WIDTH-1:0];
        send_cmd(c);
    endtask

    task automatic wait_drained();
        do begin
            @(posedge pclk);
        end while (rsps_seen != cmds_sent);
        #1;
    endtask

    // Response consumer with random back-pressure
    initial begin : consumer
        apb_rsp_t    want;
        logic [31:0] r;
        forever begin
            @(negedge pclk);
            if (!rst && rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("A response arrived with no command outstanding");
                end
                want = exp_q.pop_front();
                check_data("rsp_prdata", rsp_prdata, want.prdata);
                check_flag("rsp_pslverr", rsp_pslverr, want.pslverr);
                check_flag("rsp_pwakeup", rsp_pwakeup, want.pwakeup);
                check_user("rsp_pruser", rsp_pruser, want.pruser);
                check_user("rsp_pbuser", rsp_pbuser, want.pbuser);
                rsps_seen++;
            end
            r = rand_bits(2);
            @(posedge pclk);
            #1;
            rsp_ready = (r[1:0] != 2'b00);
        end
    end

    always @(negedge pclk) begin
        if (!rst && (parity_error_rdata || parity_error_ctrl)) begin
            report_error("A parity error flag went high on a clean bus");
        end
    end

    initial begin : watchdog
        repeat (N_CMDS * 40 + 200) @(posedge pclk);
        $display("Timeout after %0d cycles, responses still missing", N_CMDS * 40 + 200);
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_pwrite = 1'b0;
        cmd_paddr  = '0;
        cmd_pwdata = '0;
        cmd_pstrb  = '0;
        cmd_pprot  = '0;
        cmd_pauser = '0;
        cmd_pwuser = '0;
        rsp_ready  = 1'b0;
        lfsr       = 32'd25;
        cmds_sent  = 0;
        rsps_seen  = 0;
        errors     = 0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i]  = '0;
            model_wuser[i] = '0;
            model_auser[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge pclk);
        #1;
        rst = 1'b0;

        // Fields: pwrite, paddr, pwdata, pstrb, pprot, pauser, pwuser
        send_cmd({1'b1, 8'h04, 32'h0000_00a5, 4'hf, 3'b000, 4'h3, 4'h6});
        wait_drained();
        // Pending flag trails the doorbell commit by a cycle or two
        for (int i = 0; i < 4 && !wakeup_pending; i++) begin
            @(posedge pclk);
            #1;
        end
        if (!wakeup_pending) begin
            report_error("wakeup_pending never rose after the doorbell write");
        end
        send_cmd({1'b0, 8'h04, 32'h0, 4'h0, 3'b000, 4'h0, 4'h0});
        send_cmd({1'b0, 8'h04, 32'h0, 4'h0, 3'b000, 4'h0, 4'h0});

        // Protected registers and out of range indexes
        send_cmd({1'b1, 8'h24, 32'h1234_5678, 4'hf, 3'b001, 4'ha, 4'h5});
        send_cmd({1'b1, 8'h28, 32'hdead_beef, 4'hf, 3'b010, 4'h1, 4'h2});
        send_cmd({1'b0, 8'h24, 32'h0, 4'h0, 3'b000, 4'h0, 4'h0});
        send_cmd({1'b0, 8'h28, 32'h0, 4'h0, 3'b000, 4'h0, 4'h0});
        send_cmd({1'b0, 8'h44, 32'h0, 4'h0, 3'b001, 4'h0, 4'h0});
        send_cmd({1'b1, 8'h50, 32'hffff_ffff, 4'hf, 3'b001, 4'h7, 4'h7});
        wait_drained();

        repeat (N_RANDOM) random_cmd();
        wait_drained();

        if (cmds_sent != N_CMDS || rsps_seen != cmds_sent || exp_q.size() != 0) begin
            report_error("Response count does not match the commands accepted");
        end
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: apb5_subsys_top.f
source/apb5_pkg.sv
source/apb_fifo.sv
source/apb5_master.sv
source/apb5_reg_slave.sv
source/apb5_subsys_top.sv
verif/apb5_subsys_props.sv
verif/apb5_subsys_tb.sv

// File: Makefile
# Verilator build and run of the APB5 subsystem testbench
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := apb5_subsys_tb
FILELIST := apb5_subsys_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
